/* src/aes_pkg.sv */
`default_nettype none

package aes_pkg;

	localparam int NUM_ROUNDS = 10; // AES-128 round count

	// Register map, word addresses
	localparam int REG_KEY_BASE = 0; // Key words 0..3
	localparam int REG_MSG_ENC_BASE = 4; // Ciphertext words 4..7
	localparam int REG_MSG_DEC_BASE = 8; // Plaintext words 8..11
	localparam int REG_START = 14; // Bit 0 starts the core
	localparam int REG_DONE = 15; // Bit 0 mirrors core done

	typedef struct packed {
		logic [0:15][7:0] b; // b[0] is FIPS byte 0, sits in the MSBs
	} aes_block_t;

	typedef struct packed {
		aes_block_t key; // Cipher key, words 0..3
		aes_block_t ciphertext; // Input block, words 4..7
	} aes_job_t;

	typedef struct packed {
		logic read; // Bus read strobe
		logic write; // Bus write strobe
		logic cs; // Chip select
		logic [3:0] byte_en; // One bit per data byte
		logic [3:0] addr; // Word address
		logic [31:0] write_data;
	} avl_req_t;

	// Multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				p = p ^ x; // Accumulate partial product
			end
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00); // xtime
		end
		return p;
	endfunction

	// Multiplicative inverse as a^254, maps zero to zero
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] p;
		logic [7:0] r;
		r = 8'h01;
		p = a;
		for (int i = 1; i < 8; i++) begin
			p = gf_mul(p, p); // a^(2^i)
			r = gf_mul(r, p); // Collect a^2 * a^4 * ... * a^128
		end
		return r;
	endfunction

	function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
		return (x << n) | (x >> (8 - n)); // Rotate left within the byte
	endfunction

	// Forward S-box, inverse then affine map
	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] inv;
		inv = gf_inv(a);
		return inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
	endfunction

	// Inverse S-box, inverse affine map then inverse
	function automatic logic [7:0] inv_sbox(input logic [7:0] a);
		logic [7:0] t;
		t = rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05;
		return gf_inv(t);
	endfunction

endpackage

`default_nettype wire

/* src/aes_key_schedule.sv */
`default_nettype none

module aes_key_schedule (
	input  logic CLK,
	input  logic RESET,
	input  logic expand, // One-cycle load of round key 0
	input  aes_pkg::aes_block_t key,
	input  logic [3:0] round_sel,
	output aes_pkg::aes_block_t round_key
);

	import aes_pkg::*;

	aes_block_t rk [0:NUM_ROUNDS]; // Eleven stored round keys
	aes_block_t prev_key;
	aes_block_t next_key;
	logic [3:0] cnt; // Index of the key being produced
	logic running; // Expansion in progress
	logic [7:0] rcon; // Round constant, doubles each step
	logic [31:0] temp; // SubWord(RotWord(w3)) ^ Rcon
	logic [0:3][31:0] w; // Previous key as words with w[0] the MSW
	logic [0:3][31:0] nw; // Next key as words

	assign prev_key = rk[cnt - 4'd1];

	always_comb begin
		w = prev_key;
		// RotWord moves the top byte to the bottom, then SubWord
		temp = {sbox(w[3][23:16]), sbox(w[3][15:8]), sbox(w[3][7:0]), sbox(w[3][31:24])};
		temp = temp ^ {rcon, 24'h000000}; // Rcon only hits the top byte
		nw[0] = w[0] ^ temp;
		nw[1] = w[1] ^ nw[0]; // Each word chains on the one before
		nw[2] = w[2] ^ nw[1];
		nw[3] = w[3] ^ nw[2];
	end

	assign next_key = nw;

	always_ff @(posedge CLK) begin
		if (RESET) begin
			cnt <= 4'd0;
			running <= 1'b0;
			rcon <= 8'h01;
		end else if (expand) begin
			cnt <= 4'd1; // Key 1 comes next
			running <= 1'b1;
			rcon <= 8'h01;
		end else if (running) begin
			cnt <= cnt + 4'd1;
			rcon <= gf_mul(rcon, 8'h02); // Next power of x
			if (cnt == 4'(NUM_ROUNDS)) begin
				running <= 1'b0; // Key 10 written this edge
			end
		end
	end

	// Round key storage
	always_ff @(posedge CLK) begin
		if (expand) begin
			rk[0] <= key; // Round key 0 is the cipher key
		end else if (running) begin
			rk[cnt] <= next_key;
		end
	end

	assign round_key = rk[round_sel]; // Random read by the core

endmodule

`default_nettype wire

/* src/aes_inv_round.sv */
`default_nettype none

module aes_inv_round (
	input  aes_pkg::aes_block_t state_in,
	input  aes_pkg::aes_block_t round_key,
	input  logic last, // Final round skips InvMixColumns
	output aes_pkg::aes_block_t state_out
);

	import aes_pkg::*;

	aes_block_t shifted; // After InvShiftRows
	aes_block_t subbed; // After InvSubBytes
	aes_block_t keyed; // After AddRoundKey
	aes_block_t mixed; // After InvMixColumns

	// Byte 4*c + r is row r of column c
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				// Row r rotates right by r columns
				shifted.b[4*c + r] = state_in.b[4*((c + 4 - r) % 4) + r];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			subbed.b[i] = inv_sbox(shifted.b[i]); // Per-byte lookup
		end
	end

	assign keyed = subbed ^ round_key;

	always_comb begin
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		for (int c = 0; c < 4; c++) begin
			a0 = keyed.b[4*c];
			a1 = keyed.b[4*c + 1];
			a2 = keyed.b[4*c + 2];
			a3 = keyed.b[4*c + 3];
			// Circulant matrix 0e 0b 0d 09
			mixed.b[4*c] = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^
				gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
			mixed.b[4*c + 1] = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^
				gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
			mixed.b[4*c + 2] = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^
				gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
			mixed.b[4*c + 3] = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^
				gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
		end
	end

	assign state_out = last ? keyed : mixed; // Bypass mix on last round

endmodule

`default_nettype wire

/* src/aes_decrypt_core.sv */
`default_nettype none

module aes_decrypt_core (
	input  logic CLK,
	input  logic RESET,
	input  aes_pkg::aes_job_t job, // Key and ciphertext, stable while start
	input  logic start, // Level from the register file
	output aes_pkg::aes_block_t plaintext,
	output logic done // Held until start drops
);

	import aes_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_expand, // Waiting on key schedule
		st_rounds, // One inverse round per clock
		st_finished // Result held
	} core_state_t;

	core_state_t fsm;
	logic [3:0] rnd; // Round counter, also the key index
	logic expand;
	logic last;
	aes_block_t state_q; // AES state register
	aes_block_t rk; // Round key at index rnd
	aes_block_t round_out;

	assign expand = (fsm == st_idle) && start; // Pulse, fsm leaves idle next edge
	assign last = (rnd == 4'd0); // Key 0 marks the final round
	assign done = (fsm == st_finished);
	assign plaintext = state_q;

	aes_key_schedule u_key_schedule (
		.CLK,
		.RESET,
		.expand,
		.key(job.key),
		.round_sel(rnd),
		.round_key(rk)
	);

	aes_inv_round u_inv_round (
		.state_in(state_q),
		.round_key(rk),
		.last,
		.state_out(round_out)
	);

	always_ff @(posedge CLK) begin
		if (RESET) begin
			fsm <= st_idle;
			rnd <= 4'd0;
		end else begin
			case (fsm)
				st_idle: begin
					if (start) begin
						fsm <= st_expand;
						rnd <= 4'd0;
					end
				end
				st_expand: begin
					// rnd tracks the newest key written by the schedule
					if (rnd == 4'(NUM_ROUNDS)) begin
						fsm <= st_rounds;
						rnd <= 4'(NUM_ROUNDS - 1); // Count down from here
					end else begin
						rnd <= rnd + 4'd1;
					end
				end
				st_rounds: begin
					if (last) begin
						fsm <= st_finished; // rnd parks at zero
					end else begin
						rnd <= rnd - 4'd1;
					end
				end
				st_finished: begin
					if (!start) begin
						fsm <= st_idle; // Software acknowledged
					end
				end
				default: fsm <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			state_q <= '0; // Plaintext words read zero after reset
		end else if (fsm == st_expand && rnd == 4'(NUM_ROUNDS)) begin
			state_q <= job.ciphertext ^ rk; // Initial AddRoundKey with key 10
		end else if (fsm == st_rounds) begin
			state_q <= round_out;
		end
	end

endmodule

`default_nettype wire

/* src/avalon_aes_interface.sv */
`default_nettype none

// Register map
//   0..3   key, word 0 most significant
//   4..7   ciphertext
//   8..11  plaintext, written by hardware
//   12..13 unused
//   14     start, bit 0
//   15     done, bit 0
module avalon_aes_interface (
	input  logic CLK,
	input  logic RESET,
	input  aes_pkg::avl_req_t avl_req,
	output logic [31:0] read_data, // Zero unless cs and read
	output logic [31:0] export_data, // Key bits for board LEDs
	output aes_pkg::aes_job_t job,
	output logic start,
	input  aes_pkg::aes_block_t plaintext,
	input  logic done
);

	import aes_pkg::*;

	logic [31:0] regs [16]; // Sixteen-word register file
	logic [0:3][31:0] dec_words; // Plaintext split into bus words
	logic bus_write;

	assign bus_write = avl_req.write && avl_req.cs;
	assign dec_words = plaintext;

	always_ff @(posedge CLK) begin
		if (RESET) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 32'h0; // Whole file, start included
			end
		end else if (bus_write) begin
			for (int i = 0; i < 4; i++) begin
				if (avl_req.byte_en[i]) begin
					regs[avl_req.addr][8*i +: 8] <= avl_req.write_data[8*i +: 8];
				end
			end
		end else begin
			// Hardware updates yield to the bus
			for (int i = 0; i < 4; i++) begin
				regs[REG_MSG_DEC_BASE + i] <= dec_words[i];
			end
			regs[REG_DONE][0] <= done;
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			start <= 1'b0;
		end else begin
			start <= regs[REG_START][0]; // One cycle behind the register
		end
	end

	// Combinational read, no wait states
	assign read_data = (avl_req.cs && avl_req.read) ? regs[avl_req.addr] : 32'h0;

	assign export_data = {regs[REG_KEY_BASE][15:0], regs[REG_KEY_BASE + 3][31:16]};

	assign job.key = {
		regs[REG_KEY_BASE],
		regs[REG_KEY_BASE + 1],
		regs[REG_KEY_BASE + 2],
		regs[REG_KEY_BASE + 3]
	};

	assign job.ciphertext = {
		regs[REG_MSG_ENC_BASE],
		regs[REG_MSG_ENC_BASE + 1],
		regs[REG_MSG_ENC_BASE + 2],
		regs[REG_MSG_ENC_BASE + 3]
	};

endmodule

`default_nettype wire

/* src/aes_top.sv */
`default_nettype none

module aes_top (
	input  logic CLK,
	input  logic RESET,
	input  aes_pkg::avl_req_t avl_req, // Slave port request
	output logic [31:0] read_data,
	output logic [31:0] export_data // LED conduit
);

	import aes_pkg::*;

	aes_job_t job; // Key and ciphertext to the core
	aes_block_t plaintext; // Result back to the register file
	logic start;
	logic done;

	avalon_aes_interface u_interface (
		.CLK,
		.RESET,
		.avl_req,
		.read_data,
		.export_data,
		.job,
		.start,
		.plaintext,
		.done
	);

	aes_decrypt_core u_core (
		.CLK,
		.RESET,
		.job,
		.start,
		.plaintext,
		.done
	);

endmodule

`default_nettype wire

/* include/tb_aes_model.svh */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Forward AES-128 reference, relies on aes_pkg imported by the includer
// Byte 4*c + r is row r of column c, byte 0 in the top bits

function automatic logic [7:0] round_constant(input int round);
	logic [0:9][7:0] rc_table;
	rc_table = 80'h01020408102040801b36; // FIPS-197 Rcon, rounds 1..10
	return rc_table[round - 1];
endfunction

function automatic logic [0:15][7:0] next_round_key(input logic [0:15][7:0] k, input int round);
	logic [0:15][7:0] n;
	logic [0:3][7:0] t;
	t[0] = sbox(k[13]) ^ round_constant(round); // RotWord of the last word
	t[1] = sbox(k[14]);
	t[2] = sbox(k[15]);
	t[3] = sbox(k[12]);
	for (int i = 0; i < 16; i++) begin
		if (i < 4) begin
			n[i] = k[i] ^ t[i];
		end else begin
			n[i] = k[i] ^ n[i - 4]; // Chain on the word just built
		end
	end
	return n;
endfunction

function automatic logic [0:15][7:0] sub_shift(input logic [0:15][7:0] s);
	logic [0:15][7:0] o;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			o[4*c + r] = sbox(s[4*((c + r) % 4) + r]); // Row r rotates left by r
		end
	end
	return o;
endfunction

function automatic logic [0:15][7:0] mix_columns(input logic [0:15][7:0] s);
	logic [0:15][7:0] o;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			// Circulant 02 03 01 01
			o[4*c + r] = gf_mul(s[4*c + r], 8'h02) ^ gf_mul(s[4*c + (r + 1) % 4], 8'h03) ^
				s[4*c + (r + 2) % 4] ^ s[4*c + (r + 3) % 4];
		end
	end
	return o;
endfunction

function automatic logic [0:15][7:0] encrypt_block(input logic [0:15][7:0] key,
		input logic [0:15][7:0] pt);
	logic [0:15][7:0] k;
	logic [0:15][7:0] s;
	k = key;
	s = pt ^ key; // Initial AddRoundKey
	for (int round = 1; round <= NUM_ROUNDS; round++) begin
		s = sub_shift(s);
		if (round != NUM_ROUNDS) begin
			s = mix_columns(s); // Last round has no MixColumns
		end
		k = next_round_key(k, round);
		s = s ^ k;
	end
	return s;
endfunction

`endif

/* testbench/tb_aes_top.sv */
`default_nettype none

module tb_aes_top;

	timeunit 1ns;
	timeprecision 100ps;

	import aes_pkg::*;

	`include "tb_aes_model.svh"

	localparam int NUM_JOBS = 20; // Random round trips
	localparam int NUM_PARTIAL = 40; // Byte-enable writes
	localparam int POLL_LIMIT = 40; // Core needs about 25 cycles
	localparam int JOB_OPS = 24; // Writes, readbacks and result reads per job
	localparam int CYCLE_LIMIT = (NUM_JOBS + 1) * (2 * POLL_LIMIT + JOB_OPS) +
		2 * NUM_PARTIAL + 64 + 200; // Last term is margin

	logic CLK;
	logic RESET;
	avl_req_t avl_req;
	logic [31:0] read_data;
	logic [31:0] export_data;

	logic [31:0] shadow [0:7]; // Expected key and ciphertext words
	logic [15:0] lfsr = 16'd43126;
	int cycles = 0;

	aes_top dut (
		.CLK,
		.RESET,
		.avl_req,
		.read_data,
		.export_data
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			abort_run($sformatf("Timeout after %0d cycles", CYCLE_LIMIT));
		end
	end

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]}; // One step per bit
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [0:3][31:0] random_block();
		logic [0:3][31:0] blk;
		for (int i = 0; i < 4; i++) begin
			blk[i] = random_bits(32);
		end
		return blk;
	endfunction

	task automatic abort_run(input string reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abort_run("Value mismatch");
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] be);
		@(posedge CLK);
		#1;
		avl_req = '0;
		avl_req.write = 1'b1;
		avl_req.cs = 1'b1;
		avl_req.byte_en = be;
		avl_req.addr = addr;
		avl_req.write_data = data; // Captured on the next edge
	endtask

	task automatic gated_read(input logic [3:0] addr, input logic cs, input logic rd,
			output logic [31:0] data);
		@(posedge CLK);
		#1;
		avl_req = '0;
		avl_req.cs = cs;
		avl_req.read = rd;
		avl_req.addr = addr;
		#1;
		data = read_data; // Sampled mid-cycle while regs are stable
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
		gated_read(addr, 1'b1, 1'b1, data);
	endtask

	// Write, mirror into shadow, read back
	task automatic write_checked(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] d;
		bus_write(addr, data, be);
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				shadow[addr[2:0]][8*i +: 8] = data[8*i +: 8];
			end
		end
		bus_read(addr, d);
		check_value($sformatf("word[%0d]", addr), d, shadow[addr[2:0]]);
		if (addr < 4'(REG_MSG_ENC_BASE)) begin
			check_value("export_data", export_data, {shadow[0][15:0], shadow[3][31:16]});
		end
	endtask

	task automatic wait_done(input logic level);
		logic [31:0] d;
		int polls;
		polls = 0;
		bus_read(4'(REG_DONE), d);
		while (d[0] !== level) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				abort_run(level ? "Done never rose after start" :
					"Done never fell after start cleared");
			end
			bus_read(4'(REG_DONE), d);
		end
		check_value("done_word", d, {31'h0, level});
	endtask

	task automatic run_job(input logic [0:3][31:0] key, input logic [0:3][31:0] ct,
			input logic [0:3][31:0] pt);
		logic [31:0] d;
		for (int i = 0; i < 4; i++) begin
			write_checked(4'(REG_KEY_BASE + i), key[i], 4'hf);
		end
		for (int i = 0; i < 4; i++) begin
			write_checked(4'(REG_MSG_ENC_BASE + i), ct[i], 4'hf);
		end
		bus_write(4'(REG_START), 32'h1, 4'hf);
		wait_done(1'b1);
		for (int i = 0; i < 4; i++) begin
			bus_read(4'(REG_MSG_DEC_BASE + i), d);
			check_value($sformatf("plaintext[%0d]", i), d, pt[i]);
		end
		bus_write(4'(REG_START), 32'h0, 4'hf); // Release the core
		wait_done(1'b0);
	endtask

	initial begin
		logic [0:3][31:0] key;
		logic [0:3][31:0] pt;
		logic [0:3][31:0] ct;
		logic [31:0] d;
		CLK = 1'b0;
		RESET = 1'b1;
		avl_req = '0;
		for (int i = 0; i < 8; i++) begin
			shadow[i] = 32'h0;
		end
		repeat (3) @(posedge CLK);
		#1;
		RESET = 1'b0;

		for (int i = 0; i < 16; i++) begin
			bus_read(4'(i), d);
			check_value($sformatf("reset word[%0d]", i), d, 32'h0);
		end

		// FIPS-197 C.1
		key = 128'h000102030405060708090a0b0c0d0e0f;
		pt = 128'h00112233445566778899aabbccddeeff;
		ct = encrypt_block(key, pt);
		check_value("model_ct[0]", ct[0], 32'h69c4e0d8);
		check_value("model_ct[1]", ct[1], 32'h6a7b0430);
		check_value("model_ct[2]", ct[2], 32'hd8cdb780);
		check_value("model_ct[3]", ct[3], 32'h70b4c55a);
		run_job(key, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, pt);

		for (int i = 0; i < 16; i++) begin
			gated_read(4'(i), 1'b1, 1'b0, d); // Read strobe low
			check_value($sformatf("no_read word[%0d]", i), d, 32'h0);
			gated_read(4'(i), 1'b0, 1'b1, d); // Chip select low
			check_value($sformatf("no_cs word[%0d]", i), d, 32'h0);
		end

		for (int j = 0; j < NUM_JOBS; j++) begin
			key = random_block();
			pt = random_block();
			ct = encrypt_block(key, pt);
			run_job(key, ct, pt);
		end

		for (int n = 0; n < NUM_PARTIAL; n++) begin
			write_checked(4'(random_bits(3)), random_bits(32), 4'(random_bits(4)));
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(4'(i), d);
			check_value($sformatf("final word[%0d]", i), d, shadow[i]);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
src/aes_pkg.sv
src/aes_key_schedule.sv
src/aes_inv_round.sv
src/aes_decrypt_core.sv
src/avalon_aes_interface.sv
src/aes_top.sv
testbench/tb_aes_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AES testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_aes_top \
		--Mdir obj_dir -o tb_aes_top &&
	./obj_dir/tb_aes_top ||
	exit 1
